// File: Makefile
VERILATOR  := verilator
TOP        := tb_game
RTL_TOP    := game_top
FILE_LIST  := verilog.f
BUILD_DIR  := obj_dir
FLAGS      := --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps -Wall
PASS_MSG   := ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)

// File: test/tb_game.sv
module tb_game import game_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TICKS_PER_SECOND = 8;
	localparam int GAME_SECONDS     = 12;
	localparam int SNITCH_SECONDS   = 3;
	localparam int CYCLE_LIMIT      = 4000;  // Six tests of about 250 cycles plus margin
	localparam int SETTLE_LIMIT     = 40;    // Two overlapping conversions at most
	localparam int SCORE_CAP        = 9999;

	logic         clock;
	logic         reset;
	logic [15:0]  ir_in_p1;
	logic [15:0]  ir_in_p2;
	logic [3:0]   house_p1;
	logic [3:0]   house_p2;
	logic         two_player_mode;
	logic         start;
	logic         end_game_early;
	logic         play_again;
	game_screen_e screen;
	logic [6:0]   seconds_left;
	logic         snitch_powerup;
	bcd_digits_t  p1_digits;
	bcd_digits_t  p2_digits;
	logic         p1_digits_valid;
	logic         p2_digits_valid;

	game_screen_e model_screen;          // Screen expected from the timer rules
	int           model_secs;
	int           model_tick;
	int           exp_p1;                // Reference scores
	int           exp_p2;
	int           errors = 0;
	int           test_start_errors;
	int           tests_passed = 0;
	int           tests_failed = 0;
	int           cycles = 0;
	bit           check_pending = 1'b0;  // Request to the checker
	bit           timer_reported;        // First timer mismatch per test only

	game_top #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.GAME_SECONDS    (GAME_SECONDS),
		.SNITCH_SECONDS  (SNITCH_SECONDS)
	) dut (.*);

	// Points of one hit, switches ordered G S H R
	function automatic int hit_points(input logic [3:0] sw, input bit doubled);
		int points;
		if (sw[3])      points = 4;
		else if (sw[2]) points = 3;
		else if (sw[1]) points = 2;
		else            points = 1;  // Ravenclaw or no house
		if (doubled) points = points * 2;
		return points;
	endfunction

	function automatic int scored(input int score, input logic [3:0] sw, input bit doubled);
		int total;
		total = score + hit_points(sw, doubled);
		if (total > SCORE_CAP) total = SCORE_CAP;  // Four display digits
		return total;
	endfunction

	function automatic bcd_digits_t to_digits(input int value);
		bcd_digits_t d;
		d.thousands = 4'((value / 1000) % 10);
		d.hundreds  = 4'((value / 100) % 10);
		d.tens      = 4'((value / 10) % 10);
		d.ones      = 4'(value % 10);
		return d;
	endfunction

	function automatic bit window_open();
		return (model_screen == SCREEN_PLAY) && (model_secs >= 1) &&
			(model_secs <= SNITCH_SECONDS);
	endfunction

	task automatic start_test();
		test_start_errors = errors;
		timer_reported    = 1'b0;
	endtask

	task automatic finish_test(input string name);
		if (errors == test_start_errors) begin
			tests_passed = tests_passed + 1;
			$display("PASS: %s", name);
		end else begin
			tests_failed = tests_failed + 1;
			$display("FAIL: %s (%0d errors)", name, errors - test_start_errors);
		end
	endtask

	// One cycle pulse on the chosen buttons
	task automatic press(input bit s, input bit e, input bit p);
		@(negedge clock);
		start          = s;
		end_game_early = e;
		play_again     = p;
		@(negedge clock);
		start          = 1'b0;
		end_game_early = 1'b0;
		play_again     = 1'b0;
	endtask

	// Both boards rise together, then drop after hold cycles
	task automatic fire(input logic [3:0] sw1, input logic [3:0] sw2, input int hold,
		input int gap);
		logic [15:0] bits1;
		logic [15:0] bits2;
		bit          doubled;
		bits1 = 16'($urandom) | (16'd1 << ($urandom % 16));  // Never all zero
		bits2 = 16'($urandom) | (16'd1 << ($urandom % 16));
		@(negedge clock);
		doubled  = window_open();  // Decoder samples the same window
		house_p1 = sw1;
		house_p2 = sw2;
		ir_in_p1 = bits1;
		ir_in_p2 = bits2;
		if (model_screen == SCREEN_PLAY) begin
			exp_p1 = scored(exp_p1, sw1, doubled);
			if (two_player_mode) exp_p2 = scored(exp_p2, sw2, doubled);
		end
		repeat (hold) @(negedge clock);
		ir_in_p1 = '0;
		ir_in_p2 = '0;
		repeat (gap) @(negedge clock);
	endtask

	task automatic verify_scores();
		check_pending = 1'b1;
		wait (!check_pending);
	endtask

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// Screen and countdown model
	always @(posedge clock) begin
		if (reset) begin
			model_screen <= SCREEN_LOGO;
			model_secs   <= 0;
			model_tick   <= 0;
		end else begin
			case (model_screen)
				SCREEN_LOGO: begin
					if (start) begin
						model_screen <= SCREEN_PLAY;
						model_secs   <= GAME_SECONDS;
						model_tick   <= 0;
					end
				end
				SCREEN_PLAY: begin
					if (end_game_early) begin
						model_screen <= SCREEN_LEADERBOARD;  // Seconds stay frozen
					end else if (model_tick == TICKS_PER_SECOND - 1) begin
						model_tick <= 0;
						model_secs <= model_secs - 1;
						if (model_secs == 1) model_screen <= SCREEN_LEADERBOARD;
					end else begin
						model_tick <= model_tick + 1;
					end
				end
				SCREEN_LEADERBOARD: if (play_again) model_screen <= SCREEN_LOGO;
				default: model_screen <= SCREEN_LOGO;
			endcase
		end
	end

	always @(negedge clock) begin
		if (!reset && !timer_reported) begin
			assert (screen == model_screen && seconds_left == 7'(model_secs) &&
				snitch_powerup == window_open())
			else begin
				$display("[ERROR] %0t: timer shows %s %0d s snitch %0b, expected %s %0d s snitch %0b",
					$time, screen.name(), seconds_left, snitch_powerup, model_screen.name(),
					model_secs, window_open());
				errors         = errors + 1;
				timer_reported = 1'b1;
			end
		end
	end

	// Digit checker, waits for both converters to stay valid
	initial begin : digit_checker
		int          stable;
		int          waited;
		bcd_digits_t want_p1;
		bcd_digits_t want_p2;
		forever begin
			wait (check_pending);
			repeat (3) @(negedge clock);  // Score reaches the converter
			stable = 0;
			waited = 0;
			while (stable < 2 && waited < SETTLE_LIMIT) begin
				@(negedge clock);
				waited = waited + 1;
				if (p1_digits_valid && p2_digits_valid) stable = stable + 1;
				else stable = 0;
			end
			if (stable < 2) begin
				$display("Digits never settled as valid within %0d cycles at %0t", SETTLE_LIMIT, $time);
				errors = errors + 1;
			end else begin
				want_p1 = to_digits(exp_p1);
				want_p2 = to_digits(exp_p2);
				assert (p1_digits == want_p1)
				else begin
					$display("[ERROR] %0t: player 1 digits %h, expected %h", $time, p1_digits, want_p1);
					errors = errors + 1;
				end
				assert (p2_digits == want_p2)
				else begin
					$display("[ERROR] %0t: player 2 digits %h, expected %h", $time, p2_digits, want_p2);
					errors = errors + 1;
				end
			end
			check_pending = 1'b0;
		end
	end

	initial begin
		logic [3:0] sw;
		int         i;
		void'($urandom(32'h8015));
		reset           = 1'b1;
		ir_in_p1        = '0;
		ir_in_p2        = '0;
		house_p1        = '0;
		house_p2        = '0;
		two_player_mode = 1'b0;
		start           = 1'b0;
		end_game_early  = 1'b0;
		play_again      = 1'b0;
		exp_p1          = 0;
		exp_p2          = 0;
		repeat (16) @(negedge clock);
		reset = 1'b0;

		start_test();
		@(negedge clock);
		assert (screen == SCREEN_LOGO && seconds_left == 7'd0 && !snitch_powerup)
		else begin
			$display("[ERROR] %0t: after reset screen %s, %0d s, snitch %0b", $time,
				screen.name(), seconds_left, snitch_powerup);
			errors = errors + 1;
		end
		assert (p1_digits == '0 && p2_digits == '0 && p1_digits_valid && p2_digits_valid)
		else begin
			$display("[ERROR] %0t: after reset digits %h %h valid %0b %0b", $time, p1_digits,
				p2_digits, p1_digits_valid, p2_digits_valid);
			errors = errors + 1;
		end
		repeat (3) fire(4'($urandom), 4'($urandom), 1, 2);  // Logo screen ignores hits
		verify_scores();
		finish_test("reset state and logo screen");

		start_test();
		press(1'b1, 1'b0, 1'b0);
		i = 0;
		while (model_secs > 10) begin
			sw = 4'($urandom);
			if (i == 0) sw = 4'b0000;  // No house
			if (i == 1) sw = 4'b0111;  // S wins over H and R
			fire(sw, 4'($urandom), 1 + $urandom % 3, 1 + $urandom % 4);
			i = i + 1;
		end
		verify_scores();
		finish_test("single player scoring");

		start_test();
		two_player_mode = 1'b1;
		while (model_secs > 5) begin
			sw = 4'($urandom);
			fire(sw, ~sw, 1 + $urandom % 3, 1 + $urandom % 4);  // Inverse gives another house
		end
		sw = 4'($urandom);
		fire(sw, ~sw, 10, 2);  // Held board, one hit
		verify_scores();
		finish_test("two player scoring");

		start_test();
		while (model_screen != SCREEN_LEADERBOARD) @(negedge clock);
		press(1'b0, 1'b0, 1'b1);
		press(1'b1, 1'b0, 1'b0);
		exp_p1 = 0;
		exp_p2 = 0;
		while (!window_open()) @(negedge clock);
		while (window_open()) fire(4'($urandom), 4'($urandom), 1, 1 + $urandom % 2);
		verify_scores();
		finish_test("snitch window");

		start_test();
		while (model_screen != SCREEN_LEADERBOARD) @(negedge clock);
		assert (screen == SCREEN_LEADERBOARD && seconds_left == 7'd0)
		else begin
			$display("[ERROR] %0t: at time up screen %s, %0d s", $time, screen.name(), seconds_left);
			errors = errors + 1;
		end
		repeat (3) fire(4'($urandom), 4'($urandom), 1, 2);
		verify_scores();
		press(1'b0, 1'b0, 1'b1);
		assert (screen == SCREEN_LOGO)
		else begin
			$display("[ERROR] %0t: play again gave screen %s", $time, screen.name());
			errors = errors + 1;
		end
		press(1'b1, 1'b0, 1'b0);
		exp_p1 = 0;  // New game clears both
		exp_p2 = 0;
		verify_scores();
		finish_test("time up and restart");

		start_test();
		repeat (4) @(negedge clock);
		press(1'b0, 1'b0, 1'b1);
		assert (screen == SCREEN_PLAY)
		else begin
			$display("[ERROR] %0t: play again during play gave %s", $time, screen.name());
			errors = errors + 1;
		end
		press(1'b0, 1'b1, 1'b0);
		assert (screen == SCREEN_LEADERBOARD && seconds_left > 7'd0)
		else begin
			$display("[ERROR] %0t: early end gave %s, %0d s", $time, screen.name(), seconds_left);
			errors = errors + 1;
		end
		press(1'b1, 1'b0, 1'b0);
		assert (screen == SCREEN_LEADERBOARD)
		else begin
			$display("[ERROR] %0t: start on leaderboard gave %s", $time, screen.name());
			errors = errors + 1;
		end
		press(1'b0, 1'b0, 1'b1);
		finish_test("early end and ignored pulses");

		$display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: verilog.f
verilog/game_pkg.sv
verilog/ir_hit_decode.sv
verilog/score_calc.sv
verilog/screen_timer.sv
verilog/score_to_digits.sv
verilog/game_top.sv
test/tb_game.sv

// File: verilog/game_pkg.sv
package game_pkg;

	// Screens shown by the game
	typedef enum logic [1:0] {
		SCREEN_LOGO        = 2'd0,  // Title screen, waits for start
		SCREEN_PLAY        = 2'd1,  // Countdown running, hits count
		SCREEN_LEADERBOARD = 2'd2   // Final scores, waits for play again
	} game_screen_e;

	// House chosen by a player's switches
	typedef enum logic [2:0] {
		HOUSE_NONE       = 3'd0,
		HOUSE_GRYFFINDOR = 3'd1,
		HOUSE_SLYTHERIN  = 3'd2,
		HOUSE_HUFFLEPUFF = 3'd3,
		HOUSE_RAVENCLAW  = 3'd4
	} house_e;

	localparam int SCORE_W = 14;                             // Holds up to 16383
	localparam logic [SCORE_W-1:0] SCORE_MAX = 14'd9999;     // Four display digits

	// One decoded hit from the target board
	typedef struct packed {
		logic   hit;      // Single cycle strobe
		house_e house;    // House at time of the hit
		logic   doubled;  // Snitch window active
	} hit_event_t;

	// Packed decimal score for the display
	typedef struct packed {
		logic [3:0] thousands;
		logic [3:0] hundreds;
		logic [3:0] tens;
		logic [3:0] ones;
	} bcd_digits_t;

	// Points awarded for one hit by house
	function automatic logic [3:0] house_points(input house_e house);
		logic [3:0] points;
		case (house)
			HOUSE_GRYFFINDOR: points = 4'd4;
			HOUSE_SLYTHERIN:  points = 4'd3;
			HOUSE_HUFFLEPUFF: points = 4'd2;
			HOUSE_RAVENCLAW:  points = 4'd1;
			default:          points = 4'd1;  // No house still scores
		endcase
		return points;
	endfunction

endpackage

// File: verilog/game_top.sv
module game_top import game_pkg::*; #(
	parameter int TICKS_PER_SECOND = 50_000_000,  // 50 MHz board clock
	parameter int GAME_SECONDS     = 60,
	parameter int SNITCH_SECONDS   = 10
) (
	input  logic         clock,
	input  logic         reset,
	input  logic [15:0]  ir_in_p1,         // Infrared receiver readings
	input  logic [15:0]  ir_in_p2,
	input  logic [3:0]   house_p1,         // Switches {G, S, H, R}
	input  logic [3:0]   house_p2,
	input  logic         two_player_mode,
	input  logic         start,
	input  logic         end_game_early,
	input  logic         play_again,
	output game_screen_e screen,
	output logic [6:0]   seconds_left,
	output logic         snitch_powerup,
	output bcd_digits_t  p1_digits,
	output bcd_digits_t  p2_digits,
	output logic         p1_digits_valid,
	output logic         p2_digits_valid
);

	logic               game_start;  // Clears both scores
	hit_event_t         hit_p1;
	hit_event_t         hit_p2;
	logic [SCORE_W-1:0] score_p1;
	logic [SCORE_W-1:0] score_p2;

	screen_timer #(
		.TICKS_PER_SECOND(TICKS_PER_SECOND),
		.GAME_SECONDS    (GAME_SECONDS),
		.SNITCH_SECONDS  (SNITCH_SECONDS)
	) u_timer (
		.clock         (clock),
		.reset         (reset),
		.start         (start),
		.end_game_early(end_game_early),
		.play_again    (play_again),
		.screen        (screen),
		.seconds_left  (seconds_left),
		.snitch_powerup(snitch_powerup),
		.game_start    (game_start)
	);

	ir_hit_decode u_decode (
		.clock          (clock),
		.reset          (reset),
		.ir_in_p1       (ir_in_p1),
		.ir_in_p2       (ir_in_p2),
		.house_p1       (house_p1),
		.house_p2       (house_p2),
		.two_player_mode(two_player_mode),
		.screen         (screen),
		.snitch_powerup (snitch_powerup),
		.hit_p1         (hit_p1),
		.hit_p2         (hit_p2)
	);

	// Per player scoring and display conversion
	score_calc u_score_p1 (.clock(clock), .reset(reset), .hit(hit_p1),
		.game_start(game_start), .score(score_p1));
	score_calc u_score_p2 (.clock(clock), .reset(reset), .hit(hit_p2),
		.game_start(game_start), .score(score_p2));

	score_to_digits u_digits_p1 (.clock(clock), .reset(reset), .score(score_p1),
		.digits(p1_digits), .digits_valid(p1_digits_valid));
	score_to_digits u_digits_p2 (.clock(clock), .reset(reset), .score(score_p2),
		.digits(p2_digits), .digits_valid(p2_digits_valid));

endmodule

// File: verilog/ir_hit_decode.sv
module ir_hit_decode import game_pkg::*; (
	input  logic         clock,
	input  logic         reset,
	input  logic [15:0]  ir_in_p1,         // Player 1 target sensors
	input  logic [15:0]  ir_in_p2,         // Player 2 target sensors
	input  logic [3:0]   house_p1,         // Switches {G, S, H, R}
	input  logic [3:0]   house_p2,
	input  logic         two_player_mode,  // Enables player 2
	input  game_screen_e screen,
	input  logic         snitch_powerup,
	output hit_event_t   hit_p1,
	output hit_event_t   hit_p2
);

	logic board_p1;         // Any sensor lit
	logic board_p2;
	logic board_p1_q;       // Previous sample for edge detect
	logic board_p2_q;
	logic playing;          // Hits only count on play screen
	hit_event_t event_p1;   // Next event before register
	hit_event_t event_p2;

	// Priority G over S over H over R
	function automatic house_e house_select(input logic [3:0] sw);
		house_e house;
		if (sw[3])      house = HOUSE_GRYFFINDOR;
		else if (sw[2]) house = HOUSE_SLYTHERIN;
		else if (sw[1]) house = HOUSE_HUFFLEPUFF;
		else if (sw[0]) house = HOUSE_RAVENCLAW;
		else            house = HOUSE_NONE;
		return house;
	endfunction

	assign board_p1 = |ir_in_p1;  // Collapse board to one bit
	assign board_p2 = |ir_in_p2;
	assign playing  = (screen == SCREEN_PLAY);

	always_comb begin
		event_p1.hit     = board_p1 & ~board_p1_q & playing;  // Rising edge only
		event_p1.house   = house_select(house_p1);
		event_p1.doubled = snitch_powerup;
		event_p2.hit     = board_p2 & ~board_p2_q & playing & two_player_mode;
		event_p2.house   = house_select(house_p2);
		event_p2.doubled = snitch_powerup;
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			board_p1_q <= 1'b0;
			board_p2_q <= 1'b0;
			hit_p1     <= '{hit: 1'b0, house: HOUSE_NONE, doubled: 1'b0};
			hit_p2     <= '{hit: 1'b0, house: HOUSE_NONE, doubled: 1'b0};
		end else begin
			board_p1_q <= board_p1;
			board_p2_q <= board_p2;
			hit_p1     <= event_p1;  // One cycle after the edge
			hit_p2     <= event_p2;
		end
	end

endmodule

// File: verilog/score_calc.sv
module score_calc import game_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  hit_event_t         hit,         // From the decode stage
	input  logic               game_start,  // Clears score for a new game
	output logic [SCORE_W-1:0] score
);

	logic [3:0]       base_points;  // House lookup
	logic [3:0]       points;       // After snitch doubling
	logic [SCORE_W:0] sum;          // One extra bit for overflow check
	logic [SCORE_W-1:0] score_next;

	always_comb begin
		base_points = house_points(hit.house);
		if (hit.doubled) begin
			points = base_points << 1;  // Snitch doubles, max 8
		end else begin
			points = base_points;
		end
	end

	assign sum = {1'b0, score} + {{(SCORE_W - 3){1'b0}}, points};

	// Clamp at the four digit limit
	always_comb begin
		if (sum > {1'b0, SCORE_MAX}) begin
			score_next = SCORE_MAX;
		end else begin
			score_next = sum[SCORE_W-1:0];
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			score <= '0;
		end else if (game_start) begin
			score <= '0;          // New game wins over a stray hit
		end else if (hit.hit) begin
			score <= score_next;  // Edge after the hit event
		end
	end

endmodule

// File: verilog/score_to_digits.sv
module score_to_digits import game_pkg::*; (
	input  logic               clock,
	input  logic               reset,
	input  logic [SCORE_W-1:0] score,
	output bcd_digits_t        digits,
	output logic               digits_valid  // Low while converting
);

	typedef enum logic {
		CONV_IDLE  = 1'b0,  // Waiting for a new score
		CONV_SHIFT = 1'b1   // Running double dabble
	} conv_state_e;

	localparam logic [3:0] SHIFT_LAST = 4'(SCORE_W - 1);

	conv_state_e        state;
	logic [3:0]         shift_count;  // Shifts done so far
	logic [SCORE_W-1:0] last_score;   // Value behind current digits
	logic [SCORE_W-1:0] bin_q;        // Binary bits still to shift in
	logic [15:0]        bcd_q;        // Partial BCD result
	logic [15:0]        bcd_adj;      // After add three correction
	logic [15:0]        bcd_next;     // After the shift

	// Add three to every digit of five or more, then shift
	always_comb begin
		bcd_adj = bcd_q;
		for (int i = 0; i < 4; i++) begin
			if (bcd_adj[4*i +: 4] >= 4'd5) begin
				bcd_adj[4*i +: 4] = bcd_adj[4*i +: 4] + 4'd3;
			end
		end
		bcd_next = {bcd_adj[14:0], bin_q[SCORE_W-1]};
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state        <= CONV_IDLE;
			shift_count  <= 4'd0;
			last_score   <= '0;
			digits       <= '0;  // Zero score shows as valid zeros
			digits_valid <= 1'b1;
		end else begin
			case (state)
				CONV_IDLE: begin
					if (score != last_score) begin
						last_score   <= score;  // Load cycle
						shift_count  <= 4'd0;
						digits_valid <= 1'b0;
						state        <= CONV_SHIFT;
					end
				end
				CONV_SHIFT: begin
					if (shift_count == SHIFT_LAST) begin
						digits       <= bcd_digits_t'(bcd_next);
						digits_valid <= 1'b1;
						state        <= CONV_IDLE;  // Next pass catches later changes
					end else begin
						shift_count <= shift_count + 4'd1;
					end
				end
				default: state <= CONV_IDLE;
			endcase
		end
	end

	// Datapath registers follow the state machine
	always_ff @(posedge clock) begin
		if (state == CONV_IDLE) begin
			bin_q <= score;
			bcd_q <= 16'd0;
		end else begin
			bin_q <= bin_q << 1;
			bcd_q <= bcd_next;
		end
	end

endmodule

// File: verilog/screen_timer.sv
module screen_timer import game_pkg::*; #(
	parameter int TICKS_PER_SECOND = 50_000_000,  // Clock cycles per game second
	parameter int GAME_SECONDS     = 60,          // Length of one game
	parameter int SNITCH_SECONDS   = 10           // Final doubling window
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         start,           // Pulse, logo screen only
	input  logic         end_game_early,  // Pulse, play screen only
	input  logic         play_again,      // Pulse, leaderboard only
	output game_screen_e screen,
	output logic [6:0]   seconds_left,
	output logic         snitch_powerup,
	output logic         game_start       // First cycle of play
);

	localparam int TICK_W = (TICKS_PER_SECOND > 1) ? $clog2(TICKS_PER_SECOND) : 1;
	localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(TICKS_PER_SECOND - 1);
	localparam logic [6:0] GAME_LOAD    = 7'(GAME_SECONDS);
	localparam logic [6:0] SNITCH_LIMIT = 7'(SNITCH_SECONDS);

	game_screen_e      screen_next;
	logic [TICK_W-1:0] tick_count;   // Cycles within current second
	logic              start_game;   // Accepted start pulse
	logic              second_done;  // Last tick of a game second
	logic              time_up;      // Countdown about to hit zero

	assign start_game  = (screen == SCREEN_LOGO) && start;
	assign second_done = (screen == SCREEN_PLAY) && (tick_count == TICK_LAST);
	assign time_up     = second_done && (seconds_left <= 7'd1);

	// Window covers the last few seconds but never zero
	assign snitch_powerup = (screen == SCREEN_PLAY) &&
		(seconds_left != 7'd0) && (seconds_left <= SNITCH_LIMIT);

	always_comb begin
		screen_next = screen;
		case (screen)
			SCREEN_LOGO: begin
				if (start) begin
					screen_next = SCREEN_PLAY;
				end
			end
			SCREEN_PLAY: begin
				if (end_game_early || time_up) begin
					screen_next = SCREEN_LEADERBOARD;  // Same edge as last decrement
				end
			end
			SCREEN_LEADERBOARD: begin
				if (play_again) begin
					screen_next = SCREEN_LOGO;
				end
			end
			default: screen_next = SCREEN_LOGO;  // Unused encoding recovers
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			screen       <= SCREEN_LOGO;
			seconds_left <= 7'd0;
			tick_count   <= '0;
			game_start   <= 1'b0;
		end else begin
			screen     <= screen_next;
			game_start <= start_game;  // One cycle pulse
			if (start_game) begin
				seconds_left <= GAME_LOAD;
				tick_count   <= '0;
			end else if ((screen == SCREEN_PLAY) && !end_game_early) begin
				if (second_done) begin
					tick_count <= '0;
					if (seconds_left != 7'd0) begin
						seconds_left <= seconds_left - 7'd1;
					end
				end else begin
					tick_count <= tick_count + 1'b1;
				end
			end
			// Early end freezes seconds_left for the leaderboard
		end
	end

endmodule
